// File: include/tlcs_cfg.svh
// core size settings
// data and address widths, register banking, dump map

`ifndef TLCS_CFG_SVH
`define TLCS_CFG_SVH

// word width for data, registers and internal addresses
`define TLCS_DW 16

// external address bus, upper bits are zero
`define TLCS_AW 24

// register banking
`define TLCS_BANKS 4
`define TLCS_NREG 8

// dump address that returns {S, Z, C}
`define TLCS_DMP_FLAGS 32

`endif

// File: source/tlcs_pkg.sv
// shared types for the core
// instruction opcodes, ALU operations and sequencer states

package tlcs_pkg;

    // opcode in instruction bits 15..12
    typedef enum logic [3:0] {
        OP_LDI  = 4'd0,   // immediate in next word
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_LDM  = 4'd6,   // rd <= mem[rs]
        OP_STM  = 4'd7,   // mem[rs] <= rd
        OP_INCF = 4'd8,
        OP_DECF = 4'd9,
        OP_JP   = 4'd10,  // target in next word
        OP_HALT = 4'd15
    } opcode_e;

    // ALU function select
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // sequencer
    typedef enum logic [2:0] {
        FETCH  = 3'd0,  // read instruction word at pc
        DECODE = 3'd1,
        IMM    = 3'd2,  // second word for LDI and JP
        EXEC   = 3'd3,
        MEM    = 3'd4,  // indexed load or store
        HALTED = 3'd5
    } seq_state_e;

endpackage

// File: source/tlcs_regs.sv
// banked register file with bank pointer
// two read ports, one write port, combinational dump port

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tlcs_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          rd_sel_a,
    input  logic [2:0]          rd_sel_b,
    output logic [`TLCS_DW-1:0] rd_data_a,
    output logic [`TLCS_DW-1:0] rd_data_b,
    input  logic                wr_en,
    input  logic [2:0]          wr_sel,
    input  logic [`TLCS_DW-1:0] wr_data,
    input  logic                bank_inc,
    input  logic                bank_dec,
    input  logic [5:0]          dmp_addr,
    output logic [`TLCS_DW-1:0] dmp_data
);

    localparam int NR = `TLCS_BANKS * `TLCS_NREG;
    localparam int IW = $clog2(NR);
    localparam int BW = $clog2(`TLCS_BANKS);

    logic [`TLCS_DW-1:0] rf [NR];
    logic [BW-1:0]       bank;     // current bank pointer

    // physical index is bank*8 + register
    logic [IW-1:0] idx_a;
    logic [IW-1:0] idx_b;
    logic [IW-1:0] idx_w;

    assign idx_a = {bank, rd_sel_a};
    assign idx_b = {bank, rd_sel_b};
    assign idx_w = {bank, wr_sel};

    assign rd_data_a = rf[idx_a];
    assign rd_data_b = rf[idx_b];

    // bank pointer wraps on its own width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank <= '0;
        end else if (bank_inc) begin
            bank <= bank + 1'b1;
        end else if (bank_dec) begin
            bank <= bank - 1'b1;
        end
    end

    // all registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NR; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en) begin
            rf[idx_w] <= wr_data;
        end
    end

    // out of range reads zero, top level adds the flags
    always_comb begin
        if (dmp_addr < NR)
            dmp_data = rf[dmp_addr[IW-1:0]];
        else
            dmp_data = '0;
    end

endmodule

// File: source/tlcs_alu.sv
// 16-bit ALU with flag register
// add, sub, and, or, xor; flags {S, Z, C}

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tlcs_alu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`TLCS_DW-1:0] op_a,
    input  logic [`TLCS_DW-1:0] op_b,
    input  tlcs_pkg::alu_op_e   alu_op,
    input  logic                flag_we,
    output logic [`TLCS_DW-1:0] alu_result,
    output logic [2:0]          flags      // [2] S, [1] Z, [0] C
);

    import tlcs_pkg::*;

    logic [`TLCS_DW:0] wide;   // extra bit holds carry or borrow
    logic              c_nxt;

    always_comb begin
        wide = '0;
        case (alu_op)
            ALU_ADD: wide = {1'b0, op_a} + {1'b0, op_b};
            ALU_SUB: wide = {1'b0, op_a} - {1'b0, op_b};  // msb set on borrow
            ALU_AND: wide = {1'b0, op_a & op_b};
            ALU_OR:  wide = {1'b0, op_a | op_b};
            ALU_XOR: wide = {1'b0, op_a ^ op_b};
            default: wide = {1'b0, op_a};
        endcase
    end

    assign alu_result = wide[`TLCS_DW-1:0];

    // logic ops clear carry
    assign c_nxt = (alu_op == ALU_ADD || alu_op == ALU_SUB) ? wide[`TLCS_DW] : 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= 3'b000;
        end else if (flag_we) begin
            flags[2] <= alu_result[`TLCS_DW-1];   // sign
            flags[1] <= (alu_result == '0);       // zero
            flags[0] <= c_nxt;
        end
    end

endmodule

// File: source/tlcs_ctrl.sv
// instruction sequencer
// program counter, fetch, decode, execute and halt

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tlcs_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    output logic                mem_start,
    output logic                mem_we,
    output logic [`TLCS_DW-1:0] mem_addr,
    output logic [`TLCS_DW-1:0] mem_wdata,
    input  logic                mem_done,
    input  logic [`TLCS_DW-1:0] mem_rdata,
    output logic [2:0]          rd_sel_a,
    output logic [2:0]          rd_sel_b,
    input  logic [`TLCS_DW-1:0] rd_data_a,
    input  logic [`TLCS_DW-1:0] rd_data_b,
    output logic                wr_en,
    output logic [2:0]          wr_sel,
    output logic [`TLCS_DW-1:0] wr_data,
    output logic                bank_inc,
    output logic                bank_dec,
    output tlcs_pkg::alu_op_e   alu_op,
    output logic                flag_we,
    input  logic [`TLCS_DW-1:0] alu_result,
    output logic                halted
);

    import tlcs_pkg::*;

    seq_state_e          state;
    logic [`TLCS_DW-1:0] pc;
    logic [9:0]          ir;        // bits 15..6, the rest is unused
    logic                mem_busy;  // access in flight
    logic                is_alu;
    logic                mem_state;
    opcode_e             opc;

    assign opc      = opcode_e'(ir[9:6]);
    assign rd_sel_a = ir[5:3];      // destination
    assign rd_sel_b = ir[2:0];      // source or index
    assign wr_sel   = ir[5:3];
    assign halted   = (state == HALTED);

    always_comb begin
        is_alu = 1'b1;
        alu_op = ALU_ADD;
        case (opc)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            default: is_alu = 1'b0;
        endcase
    end

    // one start pulse per memory state
    assign mem_state = (state == FETCH) || (state == IMM) || (state == MEM);
    assign mem_start = mem_state && !mem_busy;
    assign mem_addr  = (state == MEM) ? rd_data_b : pc;
    assign mem_we    = (state == MEM) && (opc == OP_STM);
    assign mem_wdata = rd_data_a;

    assign flag_we  = (state == EXEC) && is_alu;
    assign bank_inc = (state == EXEC) && (opc == OP_INCF);
    assign bank_dec = (state == EXEC) && (opc == OP_DECF);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FETCH;
            pc       <= '0;
            mem_busy <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (mem_start)
                mem_busy <= 1'b1;
            else if (mem_done)
                mem_busy <= 1'b0;
            case (state)
                FETCH: if (mem_done) begin
                    pc    <= pc + 1'b1;
                    state <= DECODE;
                end
                DECODE: begin
                    case (opc)
                        OP_LDI, OP_JP:  state <= IMM;
                        OP_LDM, OP_STM: state <= MEM;
                        OP_HALT:        state <= HALTED;
                        default:        state <= EXEC;  // alu, bank ops, nop
                    endcase
                end
                IMM: if (mem_done) begin
                    pc    <= (opc == OP_JP) ? mem_rdata : pc + 1'b1;
                    wr_en <= (opc == OP_LDI);
                    state <= FETCH;
                end
                EXEC: begin
                    wr_en <= is_alu;
                    state <= FETCH;
                end
                MEM: if (mem_done) begin
                    wr_en <= (opc == OP_LDM);
                    state <= FETCH;
                end
                default: state <= HALTED;   // stays until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && mem_done)
            ir <= mem_rdata[15:6];
        if (state == EXEC)
            wr_data <= alu_result;
        else if (mem_done)
            wr_data <= mem_rdata;   // LDI immediate or LDM data
    end

endmodule

// File: source/tlcs_memctl.sv
// memory controller, four-phase req/ack master
// shared by instruction fetch and indexed load/store

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tlcs_memctl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_start,
    input  logic                mem_we,
    input  logic [`TLCS_DW-1:0] mem_addr,
    input  logic [`TLCS_DW-1:0] mem_wdata,
    output logic                mem_done,
    output logic [`TLCS_DW-1:0] mem_rdata,
    output logic                ram_req,
    output logic                ram_we,
    output logic [`TLCS_AW-1:0] ram_addr,
    output logic [`TLCS_DW-1:0] ram_wdata,
    input  logic                ram_ack,
    input  logic [`TLCS_DW-1:0] ram_rdata
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW} mc_state_e;

    mc_state_e st;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st       <= IDLE;
            ram_req  <= 1'b0;
            ram_we   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (st)
                IDLE: if (mem_start) begin
                    ram_req <= 1'b1;
                    ram_we  <= mem_we;
                    st      <= REQ;
                end
                REQ: if (ram_ack) begin
                    ram_req <= 1'b0;
                    ram_we  <= 1'b0;
                    st      <= WAIT_LOW;
                end
                default: if (!ram_ack) begin   // ack released, cycle complete
                    mem_done <= 1'b1;
                    st       <= IDLE;
                end
            endcase
        end
    end

    // address and data held for the whole request
    always_ff @(posedge clk) begin
        if (st == IDLE && mem_start) begin
            ram_addr  <= {{(`TLCS_AW-`TLCS_DW){1'b0}}, mem_addr};
            ram_wdata <= mem_wdata;
        end
        if (st == REQ && ram_ack)
            mem_rdata <= ram_rdata;    // valid while ack is high
    end

endmodule

// File: source/tlcs_core.sv
// top level of the reduced core
// register file, ALU, sequencer and memory controller

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tlcs_core (
    input  logic                clk,
    input  logic                rst_n,
    // memory port
    output logic                ram_req,
    output logic                ram_we,
    output logic [`TLCS_AW-1:0] ram_addr,
    output logic [`TLCS_DW-1:0] ram_wdata,
    input  logic                ram_ack,
    input  logic [`TLCS_DW-1:0] ram_rdata,
    // register dump
    input  logic [5:0]          dmp_addr,
    output logic [`TLCS_DW-1:0] dmp_data,
    output logic                halted
);

    import tlcs_pkg::*;

    logic                mem_start, mem_we, mem_done;
    logic [`TLCS_DW-1:0] mem_addr, mem_wdata, mem_rdata;
    logic [2:0]          rd_sel_a, rd_sel_b, wr_sel;
    logic [`TLCS_DW-1:0] rd_data_a, rd_data_b, wr_data;
    logic                wr_en, bank_inc, bank_dec;
    alu_op_e             alu_op;
    logic                flag_we;
    logic [`TLCS_DW-1:0] alu_result;
    logic [2:0]          flags;
    logic [`TLCS_DW-1:0] regs_dmp;

    tlcs_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
        .bank_inc(bank_inc), .bank_dec(bank_dec),
        .dmp_addr(dmp_addr), .dmp_data(regs_dmp)
    );

    tlcs_alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .op_a(rd_data_a), .op_b(rd_data_b),
        .alu_op(alu_op), .flag_we(flag_we),
        .alu_result(alu_result), .flags(flags)
    );

    tlcs_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .mem_start(mem_start), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
        .bank_inc(bank_inc), .bank_dec(bank_dec),
        .alu_op(alu_op), .flag_we(flag_we), .alu_result(alu_result),
        .halted(halted)
    );

    tlcs_memctl u_memctl (
        .clk(clk), .rst_n(rst_n),
        .mem_start(mem_start), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_ack(ram_ack), .ram_rdata(ram_rdata)
    );

    // flags sit just past the last register
    assign dmp_data = (dmp_addr == 6'(`TLCS_DMP_FLAGS)) ?
                      {{(`TLCS_DW-3){1'b0}}, flags} : regs_dmp;

endmodule

// File: tests/tb_clock.sv
// free running testbench clock, 20 ns period

`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 10   // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: tests/tlcs_core_sva.sv
// memory handshake, reset and halt assertions for the core
// bound to every tlcs_core instance

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tlcs_core_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                ram_req,
    input logic                ram_we,
    input logic [`TLCS_AW-1:0] ram_addr,
    input logic [`TLCS_DW-1:0] ram_wdata,
    input logic                ram_ack,
    input logic                halted
);

    // new request only once the previous ack has dropped
    a_req_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ram_req) |-> !$past(ram_ack)
    ) else $error("ram_req rose while ram_ack was still high");

    // request fields frozen for the whole handshake
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_req && $past(ram_req) |-> $stable(ram_addr) && $stable(ram_wdata) && $stable(ram_we)
    ) else $error("address, data or write enable changed while ram_req was high");

    a_reset_idle: assert property (
        @(posedge clk) $rose(rst_n) |-> !ram_req && !ram_we && !halted
    ) else $error("memory port or halted not idle when reset was released");

    a_halt_held: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else $error("halted dropped without a reset");

endmodule

bind tlcs_core tlcs_core_sva u_tlcs_core_sva (
    .clk(clk), .rst_n(rst_n),
    .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .ram_ack(ram_ack), .halted(halted)
);

// File: tests/tb_tlcs_core.sv
// testbench for the reduced core
// memory model with random ack delay, ISA reference model, result compare, watchdog

`timescale 1ns/1ps
`include "tlcs_cfg.svh"

module tb_tlcs_core;

    import tlcs_pkg::*;

    logic                clk;
    logic                rst_n;
    logic                ram_req;
    logic                ram_we;
    logic [`TLCS_AW-1:0] ram_addr;
    logic [`TLCS_DW-1:0] ram_wdata;
    logic                ram_ack;
    logic [`TLCS_DW-1:0] ram_rdata;
    logic [5:0]          dmp_addr;
    logic [`TLCS_DW-1:0] dmp_data;
    logic                halted;

    logic [15:0] image   [256];   // program and data at reset
    logic [15:0] mem     [256];   // memory seen by the DUT
    logic [15:0] ref_mem [256];
    logic [15:0] exp_rf  [32];    // bank*8 + register
    logic [2:0]  exp_flags;       // {S, Z, C}
    logic [2:0]  exp_flag_seq  [$];   // each change of the flags in program order
    logic [2:0]  seen_flag_seq [$];   // changes seen on the dump port while running
    logic [7:0]  prog_len = 8'd0;
    integer      seed = 35293;

    tb_clock u_clock (.clk(clk));

    tlcs_core u_tlcs_core (
        .clk(clk), .rst_n(rst_n),
        .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_ack(ram_ack), .ram_rdata(ram_rdata),
        .dmp_addr(dmp_addr), .dmp_data(dmp_data), .halted(halted)
    );

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [15:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs);
        return {op, rd, rs, 6'd0};
    endfunction

    task automatic emit_word(input logic [15:0] w);
        image[prog_len] = w;
        prog_len = prog_len + 8'd1;
    endtask

    task automatic emit_op(input logic [3:0] op, input logic [2:0] rd, input logic [2:0] rs);
        emit_word(encode(op, rd, rs));
    endtask

    task automatic emit_ldi(input logic [2:0] rd, input logic [15:0] value);
        emit_word(encode(OP_LDI, rd, 3'd0));
        emit_word(value);
    endtask

    task automatic build_program();
        logic [7:0] jp_slot;
        for (int i = 0; i < 256; i++) begin
            image[i[7:0]] = {i[7:0], ~i[7:0]};
        end
        emit_ldi(3'd1, 16'hFFFF);
        emit_ldi(3'd2, 16'h0001);
        emit_op(OP_ADD, 3'd1, 3'd2);        // wraps to zero with carry out
        emit_ldi(3'd3, 16'h1234);
        emit_ldi(3'd4, 16'h5678);
        emit_op(OP_SUB, 3'd3, 3'd4);        // borrow, negative
        emit_ldi(3'd5, 16'hF0F0);
        emit_op(OP_AND, 3'd5, 3'd4);
        emit_op(OP_OR, 3'd4, 3'd3);
        emit_op(OP_XOR, 3'd2, 3'd5);
        emit_op(4'd11, 3'd2, 3'd2);         // unused opcode acts as nop
        // round trip through index registers
        emit_ldi(3'd6, 16'h0090);
        emit_ldi(3'd7, 16'h0091);
        emit_op(OP_STM, 3'd3, 3'd6);
        emit_op(OP_STM, 3'd4, 3'd7);
        emit_op(OP_LDM, 3'd0, 3'd6);
        emit_op(OP_LDM, 3'd1, 3'd7);
        emit_ldi(3'd5, 16'h00C4);
        emit_op(OP_LDM, 3'd5, 3'd5);        // fill pattern word
        // banks 1, 2, 3, wrap to 0, then back down through the wrap
        emit_op(OP_INCF, 3'd0, 3'd0);
        emit_ldi(3'd0, 16'h1000);
        emit_ldi(3'd7, 16'h1007);
        emit_op(OP_INCF, 3'd0, 3'd0);
        emit_ldi(3'd3, 16'h2003);
        emit_op(OP_INCF, 3'd0, 3'd0);
        emit_ldi(3'd5, 16'h3005);
        emit_op(OP_INCF, 3'd0, 3'd0);
        emit_ldi(3'd2, 16'h0B02);
        emit_op(OP_DECF, 3'd0, 3'd0);
        emit_op(OP_DECF, 3'd0, 3'd0);
        emit_op(OP_DECF, 3'd0, 3'd0);
        emit_ldi(3'd4, 16'h1004);
        emit_op(OP_DECF, 3'd0, 3'd0);
        emit_op(OP_DECF, 3'd0, 3'd0);       // bank 0 down to bank 3
        emit_ldi(3'd2, 16'h3002);
        emit_op(OP_ADD, 3'd2, 3'd5);
        emit_ldi(3'd4, 16'h00A0);
        emit_op(OP_STM, 3'd2, 3'd4);
        emit_op(OP_LDM, 3'd6, 3'd4);
        // jump over code that must never run
        jp_slot = prog_len + 8'd1;
        emit_op(OP_JP, 3'd0, 3'd0);
        emit_word(16'h0000);
        emit_ldi(3'd7, 16'hDEAD);
        emit_ldi(3'd0, 16'hBEEF);
        emit_op(OP_INCF, 3'd0, 3'd0);
        image[jp_slot] = {8'd0, prog_len};
        emit_ldi(3'd1, 16'h3001);
        emit_op(OP_SUB, 3'd1, 3'd5);        // leaves S and C set
        emit_op(OP_HALT, 3'd0, 3'd0);
    endtask

    // ISA model of the program image that fills exp_rf, the flags and ref_mem
    function automatic void run_reference();
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic        c;
        logic [2:0]  flg;
        logic [1:0]  bank;
        logic [4:0]  d;
        logic [4:0]  s;
        logic [3:0]  op;
        bit          done;
        int          steps;
        pc = 16'd0;
        bank = 2'd0;
        exp_flags = 3'd0;
        done = 1'b0;
        steps = 0;
        ref_mem = image;
        for (int i = 0; i < 32; i++) begin
            exp_rf[i[4:0]] = 16'd0;
        end
        while (!done && steps < 1000) begin
            ir = ref_mem[pc[7:0]];
            pc = pc + 16'd1;
            op = ir[15:12];
            d = {bank, ir[11:9]};
            s = {bank, ir[8:6]};
            a = exp_rf[d];
            b = exp_rf[s];
            c = 1'b0;
            case (op)
                OP_LDI: begin
                    exp_rf[d] = ref_mem[pc[7:0]];
                    pc = pc + 16'd1;
                end
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    if (op == OP_ADD) begin
                        {c, r} = {1'b0, a} + {1'b0, b};
                    end else if (op == OP_SUB) begin
                        r = a - b;
                        c = (a < b);            // borrow
                    end else if (op == OP_AND) begin
                        r = a & b;
                    end else if (op == OP_OR) begin
                        r = a | b;
                    end else begin
                        r = a ^ b;
                    end
                    exp_rf[d] = r;
                    flg = {r[15], (r == 16'd0), c};
                    if (flg != exp_flags)
                        exp_flag_seq.push_back(flg);
                    exp_flags = flg;
                end
                OP_LDM:  exp_rf[d] = ref_mem[b[7:0]];
                OP_STM:  ref_mem[b[7:0]] = a;
                OP_INCF: bank = bank + 2'd1;
                OP_DECF: bank = bank - 2'd1;
                OP_JP:   pc = ref_mem[pc[7:0]];
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            steps++;
        end
    endfunction

    // memory model answering each request after 0 to 3 cycles
    initial begin : memory_model
        int delay;
        ram_ack = 1'b0;
        ram_rdata = 16'd0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && ram_req && !ram_ack) begin
                delay = $random(seed) & 3;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                check_value(ram_addr[23:8], 16'h0000, "upper address bits");
                if (ram_we)
                    mem[ram_addr[7:0]] = ram_wdata;
                else
                    ram_rdata = mem[ram_addr[7:0]];
                ram_ack = 1'b1;
                @(posedge clk);
                #1;
                while (ram_req) begin     // ack held until req drops
                    @(posedge clk);
                    #1;
                end
                ram_ack = 1'b0;
            end
        end
    end

    // flags on the dump port while the program runs
    initial begin : flag_monitor
        logic [2:0] last;
        last = 3'd0;
        wait (rst_n === 1'b1);
        while (halted !== 1'b1) begin
            @(negedge clk);
            if (dmp_data[2:0] !== last) begin
                last = dmp_data[2:0];
                seen_flag_seq.push_back(last);
            end
        end
    end

    task automatic compare_results();
        for (int a = 0; a < 32; a++) begin
            @(posedge clk);
            #1;
            dmp_addr = a[5:0];
            @(negedge clk);
            check_value(dmp_data, exp_rf[a[4:0]],
                        $sformatf("bank %0d register r%0d", a / 8, a % 8));
        end
        @(posedge clk);
        #1;
        dmp_addr = 6'(`TLCS_DMP_FLAGS);
        @(negedge clk);
        check_value(dmp_data, {13'd0, exp_flags}, "flags {S, Z, C}");
        check_value(16'(seen_flag_seq.size()), 16'(exp_flag_seq.size()),
                    "number of flag changes");
        for (int i = 0; i < exp_flag_seq.size(); i++) begin
            check_value({13'd0, seen_flag_seq[i]}, {13'd0, exp_flag_seq[i]},
                        $sformatf("flag change %0d {S, Z, C}", i));
        end
        for (int i = 0; i < 256; i++) begin
            check_value(mem[i[7:0]], ref_mem[i[7:0]], $sformatf("memory word %02h", i));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        dmp_addr = 6'(`TLCS_DMP_FLAGS);   // flags watched while running
        build_program();
        mem = image;
        run_reference();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value({13'd0, ram_req, ram_we, halted}, 16'd0, "outputs during reset");
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        $display("core halted at time %0t", $time);
        compare_results();
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value({15'd0, halted}, 16'd1, "halted held after HALT");
        check_value({15'd0, ram_req}, 16'd0, "no memory request while halted");
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin : watchdog
        int unsigned limit;
        wait (prog_len != 8'd0);
        limit = 32'(prog_len) * 200 * 8;   // 200 cycles per program word times 8
        repeat (limit) @(posedge clk);
        if (halted !== 1'b1)
            $display("ERROR: the core never halted within %0d cycles", limit);
        else
            $display("ERROR: the result comparison did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: project.f
+incdir+include
source/tlcs_pkg.sv
source/tlcs_regs.sv
source/tlcs_alu.sv
source/tlcs_ctrl.sv
source/tlcs_memctl.sv
source/tlcs_core.sv
tests/tb_clock.sv
tests/tlcs_core_sva.sv
tests/tb_tlcs_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_tlcs_core -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tlcs_core > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
